// ==== src/cpuDatapathPkg.sv ====
package cpuDatapathPkg;

    // Word and register file sizes.
    localparam int dataWidth  = 32;
    localparam int numRegs    = 16;
    localparam int aluOpWidth = 5;

    // ALU operation codes, as found in IR bits 31..27.
    localparam logic [aluOpWidth-1:0] aluAdd  = 5'd3;
    localparam logic [aluOpWidth-1:0] aluSub  = 5'd4;
    localparam logic [aluOpWidth-1:0] aluAnd  = 5'd5;
    localparam logic [aluOpWidth-1:0] aluOr   = 5'd6;
    localparam logic [aluOpWidth-1:0] aluShr  = 5'd7;
    localparam logic [aluOpWidth-1:0] aluShra = 5'd8;
    localparam logic [aluOpWidth-1:0] aluShl  = 5'd9;
    localparam logic [aluOpWidth-1:0] aluRor  = 5'd10;
    localparam logic [aluOpWidth-1:0] aluRol  = 5'd11;   // Matches the rol instruction word.
    localparam logic [aluOpWidth-1:0] aluMul  = 5'd12;
    localparam logic [aluOpWidth-1:0] aluDiv  = 5'd13;
    localparam logic [aluOpWidth-1:0] aluNeg  = 5'd14;
    localparam logic [aluOpWidth-1:0] aluNot  = 5'd15;

    // The two-word ALU result, as seen by the Z register.
    // The product view is the full signed 64-bit product, high word on top.
    // The divide view holds the remainder in word 1 and the quotient in word 0.
    typedef union packed
    {
        logic signed [2*dataWidth-1:0] product;
        logic [1:0][dataWidth-1:0]     divide;
    } aluResult;

endpackage

// ==== src/busMux.sv ====
module busMux
    import cpuDatapathPkg::*;
(
    input  logic [numRegs-1:0][dataWidth-1:0] regWords,
    input  logic [dataWidth-1:0]              hiData,
    input  logic [dataWidth-1:0]              loData,
    input  logic [dataWidth-1:0]              zHighData,
    input  logic [dataWidth-1:0]              zLowData,
    input  logic [dataWidth-1:0]              pcData,
    input  logic [dataWidth-1:0]              mdrData,
    input  logic [numRegs-1:0]                regOut,
    input  logic                              hiOut,
    input  logic                              loOut,
    input  logic                              zHighOut,
    input  logic                              zLowOut,
    input  logic                              pcOut,
    input  logic                              mdrOut,
    output logic [dataWidth-1:0]              busData
);

    // One request bit per bus source, general registers in the low bits.
    logic [numRegs+5:0]                request;
    logic [numRegs+5:0]                grant;
    logic [numRegs+5:0][dataWidth-1:0] sources;

    assign request = {mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, regOut};

    // Source words in the same order as the request bits.
    assign sources = {mdrData, pcData, zLowData, zHighData, loData, hiData, regWords};

    // Priority encoder.
    // Isolating the lowest set bit gives the winner, so R0 has the highest priority.
    assign grant = request & (~request + 1'b1);

    // Word selector driven by the one-hot grant. The bus is zero when nothing is granted.
    always_comb
    begin
        busData = '0;
        for (int i = 0; i < numRegs + 6; i++)
        begin
            if (grant[i])
            begin
                busData = busData | sources[i];
            end
        end
    end

endmodule

// ==== src/generalRegisters.sv ====
module generalRegisters
    import cpuDatapathPkg::*;
(
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [numRegs-1:0]                regIn,
    input  logic [dataWidth-1:0]              busData,
    output logic [numRegs-1:0][dataWidth-1:0] regWords
);

    // R0 to R15, each loaded from the bus by its own strobe.
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            regWords <= '0;
        end
        else
        begin
            for (int i = 0; i < numRegs; i++)
            begin
                if (regIn[i])
                begin
                    regWords[i] <= busData;   // Several strobes may load the same word.
                end
            end
        end
    end

endmodule

// ==== src/specialRegisters.sv ====
module specialRegisters
    import cpuDatapathPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 pcIn,
    input  logic                 irIn,
    input  logic                 yIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic                 zIn,
    input  logic [dataWidth-1:0] busData,
    input  aluResult             aluOut,
    output logic [dataWidth-1:0] pcData,
    output logic [dataWidth-1:0] irData,
    output logic [dataWidth-1:0] yData,
    output logic [dataWidth-1:0] hiData,
    output logic [dataWidth-1:0] loData,
    output logic [dataWidth-1:0] zHighData,
    output logic [dataWidth-1:0] zLowData
);

    aluResult zReg;   // Both halves of Z.

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pcData <= '0;
            irData <= '0;
            yData  <= '0;
            hiData <= '0;
            loData <= '0;
            zReg   <= '0;
        end
        else
        begin
            if (pcIn) pcData <= busData;
            if (irIn) irData <= busData;
            if (yIn)  yData  <= busData;   // Operand A of the ALU.
            if (hiIn) hiData <= busData;
            if (loIn) loData <= busData;

            // Z takes the whole 64-bit result in one edge.
            if (zIn)
            begin
                zReg <= aluOut;
            end
        end
    end

    assign zHighData = zReg.product[2*dataWidth-1:dataWidth];
    assign zLowData  = zReg.product[dataWidth-1:0];

endmodule

// ==== src/memoryInterface.sv ====
module memoryInterface
    import cpuDatapathPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 read,
    input  logic [dataWidth-1:0] busData,
    input  logic [dataWidth-1:0] mdataIn,
    output logic [dataWidth-1:0] marData,
    output logic [dataWidth-1:0] mdrData
);

    logic [dataWidth-1:0] mdrNext;

    // Memory data comes in on a read, bus data on a write setup.
    assign mdrNext = read ? mdataIn : busData;

    // Address register.
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            marData <= '0;
        end
        else if (marIn)
        begin
            marData <= busData;
        end
    end

    // Data register.
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            mdrData <= '0;
        end
        else if (mdrIn)
        begin
            mdrData <= mdrNext;
        end
    end

endmodule

// ==== src/alu.sv ====
module alu
    import cpuDatapathPkg::*;
(
    input  logic [aluOpWidth-1:0] aluOp,
    input  logic [dataWidth-1:0]  a,
    input  logic [dataWidth-1:0]  b,
    output aluResult              result
);

    logic [$clog2(dataWidth)-1:0]  shiftAmount;
    logic [2*dataWidth-1:0]        doubled;
    logic [2*dataWidth-1:0]        rotRight;
    logic [2*dataWidth-1:0]        rotLeft;
    logic signed [2*dataWidth-1:0] product;
    logic [dataWidth-1:0]          quotient;
    logic [dataWidth-1:0]          remainder;
    logic                          divByZero;

    // Only the low five bits of B count as a shift amount.
    assign shiftAmount = b[$clog2(dataWidth)-1:0];

    // A next to itself, so a plain shift of the pair rotates A.
    assign doubled  = {a, a};
    assign rotRight = doubled >> shiftAmount;
    assign rotLeft  = doubled << shiftAmount;

    // Signed 64-bit product. Both operands are sign extended by the context width.
    assign product = $signed(a) * $signed(b);

    assign divByZero = (b == '0);

    // Signed division.
    always_comb
    begin
        if (divByZero)
        begin
            quotient  = '1;   // All ones.
            remainder = a;
        end
        else
        begin
            quotient  = $signed(a) / $signed(b);
            remainder = $signed(a) % $signed(b);   // Takes the sign of A.
        end
    end

    // Operation decode. Single-word results leave the high word at zero.
    always_comb
    begin
        result = '0;
        case (aluOp)
            aluAdd:
            begin
                result.divide[0] = a + b;
            end
            aluSub:
            begin
                result.divide[0] = a - b;
            end
            aluAnd:
            begin
                result.divide[0] = a & b;
            end
            aluOr:
            begin
                result.divide[0] = a | b;
            end
            aluShr:
            begin
                result.divide[0] = a >> shiftAmount;
            end
            aluShra:
            begin
                result.divide[0] = $signed(a) >>> shiftAmount;
            end
            aluShl:
            begin
                result.divide[0] = a << shiftAmount;
            end
            aluRor:
            begin
                result.divide[0] = rotRight[dataWidth-1:0];
            end
            aluRol:
            begin
                result.divide[0] = rotLeft[2*dataWidth-1:dataWidth];
            end
            aluMul:
            begin
                result.product = product;
            end
            aluDiv:
            begin
                result.divide[1] = remainder;
                result.divide[0] = quotient;
            end
            aluNeg:
            begin
                result.divide[0] = -b;
            end
            aluNot:
            begin
                result.divide[0] = ~b;
            end
            default:
            begin
                result = '0;   // Undefined code.
            end
        endcase
    end

endmodule

// ==== src/datapath.sv ====
module datapath
    import cpuDatapathPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,

    // Register load strobes.
    input  logic [numRegs-1:0]    regIn,
    input  logic                  hiIn,
    input  logic                  loIn,
    input  logic                  pcIn,
    input  logic                  irIn,
    input  logic                  yIn,
    input  logic                  zIn,
    input  logic                  marIn,
    input  logic                  mdrIn,
    input  logic                  read,

    // Bus source selects.
    input  logic [numRegs-1:0]    regOut,
    input  logic                  hiOut,
    input  logic                  loOut,
    input  logic                  zHighOut,
    input  logic                  zLowOut,
    input  logic                  pcOut,
    input  logic                  mdrOut,

    input  logic [aluOpWidth-1:0] aluOp,
    input  logic [dataWidth-1:0]  mdataIn,

    output logic [dataWidth-1:0]  busData,
    output logic [dataWidth-1:0]  marData,
    output logic [dataWidth-1:0]  irData,
    output logic [dataWidth-1:0]  zHighData,
    output logic [dataWidth-1:0]  zLowData
);

    logic [numRegs-1:0][dataWidth-1:0] regWords;
    logic [dataWidth-1:0]              pcData;
    logic [dataWidth-1:0]              yData;
    logic [dataWidth-1:0]              hiData;
    logic [dataWidth-1:0]              loData;
    logic [dataWidth-1:0]              mdrData;
    aluResult                          aluOut;

    busMux busMuxInst (
        .regWords  (regWords),
        .hiData    (hiData),
        .loData    (loData),
        .zHighData (zHighData),
        .zLowData  (zLowData),
        .pcData    (pcData),
        .mdrData   (mdrData),
        .regOut    (regOut),
        .hiOut     (hiOut),
        .loOut     (loOut),
        .zHighOut  (zHighOut),
        .zLowOut   (zLowOut),
        .pcOut     (pcOut),
        .mdrOut    (mdrOut),
        .busData   (busData)
    );

    generalRegisters generalRegistersInst (
        .clk      (clk),
        .rstN     (rstN),
        .regIn    (regIn),
        .busData  (busData),
        .regWords (regWords)
    );

    // PC, IR, Y, HI, LO and Z.
    specialRegisters specialRegistersInst (
        .clk       (clk),
        .rstN      (rstN),
        .pcIn      (pcIn),
        .irIn      (irIn),
        .yIn       (yIn),
        .hiIn      (hiIn),
        .loIn      (loIn),
        .zIn       (zIn),
        .busData   (busData),
        .aluOut    (aluOut),
        .pcData    (pcData),
        .irData    (irData),
        .yData     (yData),
        .hiData    (hiData),
        .loData    (loData),
        .zHighData (zHighData),
        .zLowData  (zLowData)
    );

    memoryInterface memoryInterfaceInst (
        .clk     (clk),
        .rstN    (rstN),
        .marIn   (marIn),
        .mdrIn   (mdrIn),
        .read    (read),
        .busData (busData),
        .mdataIn (mdataIn),
        .marData (marData),
        .mdrData (mdrData)
    );

    alu aluInst (
        .aluOp  (aluOp),
        .a      (yData),     // Y holds the first operand.
        .b      (busData),
        .result (aluOut)
    );

endmodule

// ==== testbench/datapath_checker.sv ====
module datapath_checker
    import cpuDatapathPkg::*;
(
    input logic                              clk,
    input logic                              rstN,
    input logic [numRegs-1:0]                regOut,
    input logic                              hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut,
    input logic                              marIn,
    input logic [dataWidth-1:0]              busData,
    input logic [numRegs-1:0][dataWidth-1:0] regWords,
    input logic [dataWidth-1:0]              pcData, irData, yData, hiData, loData,
    input logic [dataWidth-1:0]              zHighData, zLowData, marData, mdrData
);

    timeunit 1ns;
    timeprecision 10ps;

    logic allClear;
    int   failCount = 0;   // Assertion failures so far.

    assign allClear = (regWords == '0) && (pcData == '0) && (irData == '0) && (yData == '0)
                      && (hiData == '0) && (loData == '0) && (zHighData == '0)
                      && (zLowData == '0) && (marData == '0) && (mdrData == '0);

    // At most one bus source.
    assert property (@(posedge clk)
        $onehot0({regOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut}))
    else
    begin
        failCount++;
        $error("More than one bus source selected");
    end

    assert property (@(posedge clk) !rstN |=> allClear)
    else
    begin
        failCount++;
        $error("A register is not zero after reset");
    end

    assert property (@(posedge clk) disable iff (!rstN) marIn |=> marData == $past(busData))
    else
    begin
        failCount++;
        $error("MAR did not capture the bus word");   // Address latch.
    end

endmodule

bind datapath datapath_checker datapathChecks (
    .clk       (clk),
    .rstN      (rstN),
    .regOut    (regOut),
    .hiOut     (hiOut),
    .loOut     (loOut),
    .zHighOut  (zHighOut),
    .zLowOut   (zLowOut),
    .pcOut     (pcOut),
    .mdrOut    (mdrOut),
    .marIn     (marIn),
    .busData   (busData),
    .regWords  (regWords),
    .pcData    (pcData),
    .irData    (irData),
    .yData     (yData),
    .hiData    (hiData),
    .loData    (loData),
    .zHighData (zHighData),
    .zLowData  (zLowData),
    .marData   (marData),
    .mdrData   (mdrData)
);

// ==== testbench/datapathTb.sv ====
module datapathTb
    import cpuDatapathPkg::*;
();

    timeunit 1ns;
    timeprecision 10ps;

    localparam int numOps       = 400;
    localparam int maxOpCycles  = 6;
    localparam int timeoutLimit = numOps * maxOpCycles + 600;   // Reset and directed cases fit the margin.

    logic                  clk;
    logic                  rstN;
    logic [numRegs-1:0]    regIn;
    logic [numRegs-1:0]    regOut;
    logic                  hiIn, loIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, read;
    logic                  hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut;
    logic [aluOpWidth-1:0] aluOp;
    logic [dataWidth-1:0]  mdataIn;
    logic [dataWidth-1:0]  busData;
    logic [dataWidth-1:0]  marData;
    logic [dataWidth-1:0]  irData;
    logic [dataWidth-1:0]  zHighData;
    logic [dataWidth-1:0]  zLowData;

    // Reference copies of the DUT registers.
    logic [dataWidth-1:0]  modelRegs [numRegs];
    logic [dataWidth-1:0]  modelY, modelPc, modelMdr, modelHi, modelLo, modelZHigh, modelZLow;

    logic [aluOpWidth-1:0] basicOps [11] = '{aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShra,
                                             aluShl, aluRor, aluRol, aluNeg, aluNot};

    int errors     = 0;
    int checks     = 0;
    int cycleCount = 0;

    datapath uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Prints the counts and ends the run.
    task automatic reportAndFinish(input bit timedOut);
        int assertFails;
        assertFails = uut.datapathChecks.failCount;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timed out: %0d",
                 checks, errors, assertFails, timedOut);
        if (errors == 0 && assertFails == 0 && !timedOut)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    endtask

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            reportAndFinish(1'b1);
        end
    end

    task automatic releaseStrobes();
        regIn  <= '0;
        regOut <= '0;
        {hiIn, loIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, read} <= '0;
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut} <= '0;
    endtask

    // Next rising edge, with the previous cycle's strobes dropped.
    task automatic nextCycle();
        @(posedge clk);
        releaseStrobes();
    endtask

    task automatic checkWord(input string name, input logic [dataWidth-1:0] expected,
                             input logic [dataWidth-1:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    // Expected Z words {high, low} for one ALU operation.
    function automatic logic [2*dataWidth-1:0] modelAlu(input logic [aluOpWidth-1:0] op,
                                                        input logic [dataWidth-1:0] a,
                                                        input logic [dataWidth-1:0] b);
        longint               sa;
        longint               sb;
        logic [4:0]           n;
        logic [dataWidth-1:0] hi;
        logic [dataWidth-1:0] lo;
        sa = $signed(a);
        sb = $signed(b);
        n  = b[4:0];
        hi = '0;
        lo = '0;
        case (op)
            aluAdd:  lo = a + b;
            aluSub:  lo = a - b;
            aluAnd:  lo = a & b;
            aluOr:   lo = a | b;
            aluShr:  lo = a >> n;
            aluShra: lo = 32'(sa >>> n);
            aluShl:  lo = a << n;
            aluRor:  lo = (a >> n) | (a << (dataWidth - n));
            aluRol:  lo = (a << n) | (a >> (dataWidth - n));
            aluMul:  {hi, lo} = sa * sb;
            aluDiv:
            begin
                lo = (b == '0) ? '1 : 32'(sa / sb);
                hi = (b == '0) ? a : 32'(sa % sb);   // Remainder follows the dividend's sign.
            end
            aluNeg:  lo = -b;
            aluNot:  lo = ~b;
            default: lo = '0;
        endcase
        return {hi, lo};
    endfunction

    // Memory read into MDR.
    task automatic loadMdr(input logic [dataWidth-1:0] word);
        nextCycle();
        mdataIn <= word;
        read    <= 1'b1;
        mdrIn   <= 1'b1;
        modelMdr = word;
    endtask

    task automatic moveThroughRegister(input logic [dataWidth-1:0] word, input int k);
        loadMdr(word);
        nextCycle();
        mdrOut   <= 1'b1;
        regIn[k] <= 1'b1;
        @(negedge clk);
        checkWord("busData", modelMdr, busData);
        modelRegs[k] = modelMdr;
        nextCycle();
        regOut[k] <= 1'b1;
        @(negedge clk);
        checkWord("busData", modelRegs[k], busData);
    endtask

    // A into Y, B into Rk, then Rk drives operand B while Z loads.
    task automatic aluOperation(input logic [aluOpWidth-1:0] op, input logic [dataWidth-1:0] a,
                                input logic [dataWidth-1:0] b, input int k);
        loadMdr(a);
        nextCycle();
        mdrOut <= 1'b1;
        yIn    <= 1'b1;
        modelY = modelMdr;
        loadMdr(b);
        nextCycle();
        mdrOut   <= 1'b1;
        regIn[k] <= 1'b1;
        modelRegs[k] = modelMdr;
        nextCycle();
        regOut[k] <= 1'b1;
        aluOp     <= op;
        zIn       <= 1'b1;
        {modelZHigh, modelZLow} = modelAlu(op, modelY, modelRegs[k]);
        nextCycle();
        zLowOut <= 1'b1;
        @(negedge clk);
        checkWord("busData", modelZLow, busData);
        checkWord("zLowData", modelZLow, zLowData);
        checkWord("zHighData", modelZHigh, zHighData);
    endtask

    task automatic fetchInstruction(input logic [dataWidth-1:0] pc,
                                    input logic [dataWidth-1:0] instr);
        loadMdr(pc);
        nextCycle();
        mdrOut <= 1'b1;
        pcIn   <= 1'b1;
        modelPc = modelMdr;
        nextCycle();
        pcOut <= 1'b1;
        marIn <= 1'b1;
        @(negedge clk);
        checkWord("busData", modelPc, busData);
        loadMdr(instr);
        @(negedge clk);
        checkWord("marData", modelPc, marData);
        nextCycle();
        mdrOut <= 1'b1;
        irIn   <= 1'b1;
        nextCycle();
        @(negedge clk);
        checkWord("irData", modelMdr, irData);
    endtask

    task automatic moveHiLo();
        nextCycle();
        zHighOut <= 1'b1;
        hiIn     <= 1'b1;
        modelHi = modelZHigh;
        nextCycle();
        zLowOut <= 1'b1;
        loIn    <= 1'b1;
        modelLo = modelZLow;
        nextCycle();
        hiOut <= 1'b1;
        @(negedge clk);
        checkWord("busData", modelHi, busData);
        nextCycle();
        loOut <= 1'b1;
        @(negedge clk);
        checkWord("busData", modelLo, busData);
    endtask

    initial
    begin
        int                    choice;
        bit                    pending;
        logic [aluOpWidth-1:0] pendingOp;
        logic [dataWidth-1:0]  opA;
        logic [dataWidth-1:0]  opB;
        void'($urandom(31));
        rstN    <= 1'b0;
        aluOp   <= '0;
        mdataIn <= '0;
        releaseStrobes();
        modelRegs = '{default: '0};
        {modelY, modelPc, modelMdr, modelHi, modelLo, modelZHigh, modelZLow} = '0;
        pending = 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkWord("busData", '0, busData);
        checkWord("marData", '0, marData);
        checkWord("irData", '0, irData);
        checkWord("zHighData", '0, zHighData);
        checkWord("zLowData", '0, zLowData);

        // Reference rotate, only bits 4..0 of 28h count.
        aluOperation(aluRol, 32'h8000FA92, 32'h00000028, 1);
        checkWord("zLowData", 32'h00FA9280, zLowData);
        aluOperation(aluDiv, $urandom, '0, 2);

        for (int i = 0; i < numOps; i++)
        begin
            opA    = $urandom;
            opB    = $urandom;
            choice = pending ? 1 : $urandom_range(0, 4);
            case (choice)
                0: moveThroughRegister(opA, $urandom_range(0, numRegs - 1));
                1:
                begin
                    aluOperation(pending ? pendingOp : basicOps[$urandom_range(0, 10)],
                                 opA, opB, $urandom_range(0, numRegs - 1));
                    pending = 1'b0;
                end
                2:
                begin
                    if ($urandom_range(0, 3) == 0)
                        opB = '0;
                    if (opA == 32'h80000000 && opB == '1)
                        opB = 32'd1;   // Quotient overflow.
                    aluOperation($urandom_range(0, 1) ? aluMul : aluDiv, opA, opB,
                                 $urandom_range(0, numRegs - 1));
                end
                3:
                begin
                    fetchInstruction(opA, {basicOps[$urandom_range(0, 10)], opB[26:0]});
                    pendingOp = irData[31:27];   // Decoded by the next operation.
                    pending   = 1'b1;
                end
                default: moveHiLo();
            endcase
        end
        reportAndFinish(1'b0);
    end

endmodule

// ==== cpuDatapath.f ====
src/cpuDatapathPkg.sv
src/busMux.sv
src/generalRegisters.sv
src/specialRegisters.sv
src/memoryInterface.sv
src/alu.sv
src/datapath.sv
testbench/datapath_checker.sv
testbench/datapathTb.sv

// ==== Bender.yml ====
package:
  name: cpu_datapath

sources:
  - src/cpuDatapathPkg.sv
  - src/busMux.sv
  - src/generalRegisters.sv
  - src/specialRegisters.sv
  - src/memoryInterface.sv
  - src/alu.sv
  - src/datapath.sv
  - target: test
    files:
      - testbench/datapath_checker.sv
      - testbench/datapathTb.sv
